//--- all.f
design/cpu_pkg.sv
design/ctrl_if.sv
design/mem_if.sv
design/instr_fetch.sv
design/control_unit.sv
design/datapath.sv
design/mem_port.sv
design/cpu_top.sv
dv/cpu_tb.sv

//--- design/control_unit.sv
`timescale 1ns/1ns

module control_unit
    import cpu_pkg::*;
(
    input  logic            clock,
    input  logic            rst_n,
    input  logic            run,
    input  logic [XLEN-1:0] ir,
    input  logic            ra_zero,
    input  logic            ra_neg,
    output logic            halted,
    ctrl_if.ctrl            ctl
);

    phase_e     phase_q;
    opcode_e    op;
    logic       start;     // leave t1 this cycle
    logic       advance;
    logic       cond_met;

    assign op      = opcode_e'(ir[OP_HI:OP_LO]);
    assign start   = run && !halted;
    assign advance = (phase_q != t1_fetch) || start;  // run only checked in t1

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            phase_q <= t1_fetch;
            halted  <= 1'b0;
        end
        else
        begin
            if (advance)
            begin
                case (phase_q)
                    t1_fetch: phase_q <= t2_read;
                    t2_read:  phase_q <= t3_exec;
                    t3_exec:  phase_q <= t4_mem;
                    t4_mem:   phase_q <= t5_write;
                    default:  phase_q <= t1_fetch;
                endcase
            end
            if (phase_q == t5_write && op == op_halt)
                halted <= 1'b1;
        end
    end

    always_comb
    begin
        case (ir[COND_HI:COND_LO])
            BR_ZERO:    cond_met = ra_zero;
            BR_NONZERO: cond_met = !ra_zero;
            BR_POS:     cond_met = !ra_neg;
            default:    cond_met = ra_neg;
        endcase
    end

    always_comb
    begin
        case (op)
            op_ld, op_ldi, op_st, op_add, op_addi: ctl.alu_op = alu_add;
            op_sub:            ctl.alu_op = alu_sub;
            op_and, op_andi:   ctl.alu_op = alu_and;
            op_or, op_ori:     ctl.alu_op = alu_or;
            op_rotr:           ctl.alu_op = alu_rotr;
            op_rotl:           ctl.alu_op = alu_rotl;
            op_shr:            ctl.alu_op = alu_shr;
            op_shra:           ctl.alu_op = alu_shra;
            op_shl:            ctl.alu_op = alu_shl;
            op_mul:            ctl.alu_op = alu_mul;
            op_neg:            ctl.alu_op = alu_neg;
            op_not:            ctl.alu_op = alu_not;
            default:           ctl.alu_op = alu_pass_b;
        endcase
    end

    always_comb
    begin
        case (op)
            op_mfhi: ctl.y_sel = y_hi;
            op_mflo: ctl.y_sel = y_lo;
            op_ld:   ctl.y_sel = y_mem;
            op_jal:  ctl.y_sel = y_pc;   // link into r15
            default: ctl.y_sel = y_z;
        endcase
    end

    assign ctl.phase      = phase_q;
    assign ctl.fetch_en   = (phase_q == t1_fetch) && start;
    assign ctl.b_imm      = op inside {op_ld, op_ldi, op_st, op_addi, op_andi, op_ori};
    assign ctl.rf_write   = op inside {op_ld, op_ldi, op_add, op_sub, op_and, op_or,
                                       op_rotr, op_rotl, op_shr, op_shra, op_shl,
                                       op_addi, op_andi, op_ori, op_neg, op_not,
                                       op_jal, op_mflo, op_mfhi};
    assign ctl.hilo_write = (op == op_mul);
    assign ctl.mem_read   = (op == op_ld) && (phase_q == t4_mem);
    assign ctl.mem_write  = (op == op_st) && (phase_q == t4_mem);
    assign ctl.pc_branch  = (op == op_br) && cond_met;
    assign ctl.pc_jump    = op inside {op_jal, op_jr};

    a_phase_legal: assert property (
        @(posedge clock) disable iff (!rst_n)
        phase_q inside {t1_fetch, t2_read, t3_exec, t4_mem, t5_write}
    ) else $error("illegal phase %0d", phase_q);

    a_mem_exclusive: assert property (
        @(posedge clock) disable iff (!rst_n)
        !(ctl.mem_read && ctl.mem_write)
    ) else $error("read and write strobes together");

endmodule

//--- design/cpu_pkg.sv
package cpu_pkg;

    localparam int XLEN       = 32;
    localparam int NUM_REGS   = 16;
    localparam int REG_AW     = 4;
    localparam int IMEM_DEPTH = 64;
    localparam int IMEM_AW    = 6;

    // instruction fields
    localparam int OP_HI   = 31;
    localparam int OP_LO   = 27;
    localparam int RA_HI   = 26;
    localparam int RA_LO   = 23;
    localparam int RB_HI   = 22;
    localparam int RB_LO   = 19;
    localparam int RC_HI   = 18;
    localparam int RC_LO   = 15;
    localparam int COND_HI = 22;
    localparam int COND_LO = 21;
    localparam int IMM_HI  = 18;
    localparam int IMM_LO  = 0;

    localparam logic [REG_AW-1:0] LINK_REG = 4'd15; // jal return address

    // branch conditions, tested on the ra register
    localparam logic [1:0] BR_ZERO    = 2'b00;
    localparam logic [1:0] BR_POS     = 2'b01; // sign bit clear
    localparam logic [1:0] BR_NONZERO = 2'b10;
    localparam logic [1:0] BR_NEG     = 2'b11;

    typedef enum logic [4:0] {
        op_ld   = 5'b00000, op_ldi  = 5'b00001, op_st   = 5'b00010,
        op_add  = 5'b00011, op_sub  = 5'b00100, op_and  = 5'b00101,
        op_or   = 5'b00110, op_rotr = 5'b00111, op_rotl = 5'b01000,
        op_shr  = 5'b01001, op_shra = 5'b01010, op_shl  = 5'b01011,
        op_addi = 5'b01100, op_andi = 5'b01101, op_ori  = 5'b01110,
        op_mul  = 5'b10000, op_neg  = 5'b10001, op_not  = 5'b10010,
        op_br   = 5'b10011, op_jal  = 5'b10100, op_jr   = 5'b10101,
        op_mflo = 5'b11000, op_mfhi = 5'b11001, op_halt = 5'b11011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add  = 4'b0000, alu_sub  = 4'b0001, alu_and  = 4'b0010,
        alu_or   = 4'b0011, alu_rotr = 4'b0100, alu_rotl = 4'b0101,
        alu_shr  = 4'b0110, alu_shra = 4'b0111, alu_shl  = 4'b1000,
        alu_mul  = 4'b1010, alu_neg  = 4'b1011, alu_not  = 4'b1100,
        alu_pass_b = 4'b1101
    } alu_op_e;

    typedef enum logic [2:0] {
        t1_fetch = 3'd0, t2_read = 3'd1, t3_exec = 3'd2, t4_mem = 3'd3, t5_write = 3'd4
    } phase_e;

    typedef enum logic [2:0] {
        y_z = 3'd0, y_hi = 3'd1, y_mem = 3'd2, y_lo = 3'd3, y_pc = 3'd4
    } ybus_sel_e;

endpackage

//--- design/cpu_top.sv
`timescale 1ns/1ns

module cpu_top
    import cpu_pkg::*;
(
    input  logic               clock,
    input  logic               rst_n,
    input  logic               run,
    input  logic               prog_write,
    input  logic [IMEM_AW-1:0] prog_addr,
    input  logic [XLEN-1:0]    prog_data,
    input  logic [XLEN-1:0]    load_data,
    output logic [XLEN-1:0]    mem_addr,
    output logic [XLEN-1:0]    store_data,
    output logic               store_valid,
    output logic               load_valid,
    output logic               halted
);

    logic [XLEN-1:0]    ir;
    logic [IMEM_AW-1:0] pc;
    logic [IMEM_AW-1:0] next_pc;
    logic               ra_zero;
    logic               ra_neg;

    ctrl_if u_ctrl_if ();
    mem_if  u_mem_if ();

    instr_fetch u_instr_fetch (
        .clock      (clock),
        .rst_n      (rst_n),
        .prog_write (prog_write),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .next_pc    (next_pc),
        .ctl        (u_ctrl_if.fetch),
        .ir         (ir),
        .pc         (pc)
    );

    control_unit u_control_unit (
        .clock   (clock),
        .rst_n   (rst_n),
        .run     (run),
        .ir      (ir),
        .ra_zero (ra_zero),
        .ra_neg  (ra_neg),
        .halted  (halted),
        .ctl     (u_ctrl_if.ctrl)
    );

    datapath u_datapath (
        .clock   (clock),
        .rst_n   (rst_n),
        .ir      (ir),
        .pc      (pc),
        .ctl     (u_ctrl_if.dp),
        .mem     (u_mem_if.dp),
        .ra_zero (ra_zero),
        .ra_neg  (ra_neg),
        .next_pc (next_pc)
    );

    mem_port u_mem_port (
        .clock       (clock),
        .rst_n       (rst_n),
        .mem         (u_mem_if.port),
        .load_data   (load_data),
        .mem_addr    (mem_addr),
        .store_data  (store_data),
        .store_valid (store_valid),
        .load_valid  (load_valid)
    );

endmodule

//--- design/ctrl_if.sv
`timescale 1ns/1ns

interface ctrl_if
    import cpu_pkg::*;
();
    phase_e    phase;
    logic      fetch_en;   // t1 with the core running
    alu_op_e   alu_op;
    logic      b_imm;      // operand b from immediate
    logic      rf_write;
    ybus_sel_e y_sel;
    logic      hilo_write;
    logic      mem_read;
    logic      mem_write;
    logic      pc_branch;  // branch taken
    logic      pc_jump;    // pc from register

    modport ctrl (
        output phase, fetch_en, alu_op, b_imm, rf_write, y_sel, hilo_write,
               mem_read, mem_write, pc_branch, pc_jump
    );

    modport fetch (
        input phase, fetch_en, pc_branch, pc_jump
    );

    modport dp (
        input phase, alu_op, b_imm, rf_write, y_sel, hilo_write, mem_read, mem_write, pc_jump
    );

endinterface

//--- design/datapath.sv
`timescale 1ns/1ns

module datapath
    import cpu_pkg::*;
(
    input  logic               clock,
    input  logic               rst_n,
    input  logic [XLEN-1:0]    ir,
    input  logic [IMEM_AW-1:0] pc,
    ctrl_if.dp                 ctl,
    mem_if.dp                  mem,
    output logic               ra_zero,
    output logic               ra_neg,
    output logic [IMEM_AW-1:0] next_pc
);

    logic [XLEN-1:0]        regs [NUM_REGS];
    logic [REG_AW-1:0]      ra_idx;
    logic [REG_AW-1:0]      rb_idx;
    logic [REG_AW-1:0]      rc_idx;
    logic [REG_AW-1:0]      wr_idx;
    logic [XLEN-1:0]        ra_val;
    logic [XLEN-1:0]        a_q;
    logic [XLEN-1:0]        b_q;
    logic [XLEN-1:0]        z_q;
    logic [XLEN-1:0]        hi_q;
    logic [XLEN-1:0]        lo_q;
    logic [XLEN-1:0]        imm_ext;
    logic [XLEN-1:0]        alu_b;
    logic [XLEN-1:0]        alu_z;
    logic [XLEN-1:0]        y_bus;
    logic [4:0]             shamt;
    logic signed [2*XLEN-1:0] product;

    function automatic logic [XLEN-1:0] rf_read(input logic [REG_AW-1:0] idx);
        return (idx == '0) ? '0 : regs[idx];  // r0 hardwired
    endfunction

    assign ra_idx  = ir[RA_HI:RA_LO];
    assign rb_idx  = ir[RB_HI:RB_LO];
    assign rc_idx  = ir[RC_HI:RC_LO];
    assign imm_ext = {{(XLEN-IMM_HI-1){ir[IMM_HI]}}, ir[IMM_HI:IMM_LO]};
    assign ra_val  = rf_read(ra_idx);

    always_ff @(posedge clock)
    begin
        if (ctl.phase == t2_read)
        begin
            a_q <= rf_read(rb_idx);
            b_q <= rf_read(rc_idx);
        end
    end

    assign alu_b   = ctl.b_imm ? imm_ext : b_q;
    assign shamt   = alu_b[4:0];
    assign product = $signed(a_q) * $signed(alu_b);

    always_comb
    begin
        case (ctl.alu_op)
            alu_add:    alu_z = a_q + alu_b;
            alu_sub:    alu_z = a_q - alu_b;
            alu_and:    alu_z = a_q & alu_b;
            alu_or:     alu_z = a_q | alu_b;
            alu_rotr:   alu_z = (a_q >> shamt) | (a_q << (XLEN - shamt));
            alu_rotl:   alu_z = (a_q << shamt) | (a_q >> (XLEN - shamt));
            alu_shr:    alu_z = a_q >> shamt;
            alu_shra:   alu_z = $signed(a_q) >>> shamt;
            alu_shl:    alu_z = a_q << shamt;
            alu_mul:    alu_z = product[XLEN-1:0];
            alu_neg:    alu_z = -a_q;
            alu_not:    alu_z = ~a_q;
            alu_pass_b: alu_z = alu_b;
            default:    alu_z = '0;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (ctl.phase == t3_exec)
        begin
            z_q <= alu_z;
            if (ctl.hilo_write)
            begin
                hi_q <= product[2*XLEN-1:XLEN];  // upper product
                lo_q <= product[XLEN-1:0];
            end
        end
    end

    // memory address is z, stores send ra
    assign mem.addr  = z_q;
    assign mem.wdata = ra_val;
    assign mem.read  = ctl.mem_read;
    assign mem.write = ctl.mem_write;

    always_comb
    begin
        case (ctl.y_sel)
            y_hi:    y_bus = hi_q;
            y_lo:    y_bus = lo_q;
            y_mem:   y_bus = mem.rdata;
            y_pc:    y_bus = {{(XLEN-IMEM_AW){1'b0}}, pc};  // return address
            default: y_bus = z_q;
        endcase
    end

    assign wr_idx = (ctl.y_sel == y_pc) ? LINK_REG : ra_idx;

    always_ff @(posedge clock)
    begin
        if (ctl.phase == t5_write && ctl.rf_write)
            regs[wr_idx] <= y_bus;
    end

    assign ra_zero = (ra_val == '0);
    assign ra_neg  = ra_val[XLEN-1];
    assign next_pc = ctl.pc_jump ? ra_val[IMEM_AW-1:0] : pc + imm_ext[IMEM_AW-1:0];

    a_r0_zero: assert property (
        @(posedge clock) disable iff (!rst_n)
        (ra_idx == '0) |-> (ra_val == '0) && ra_zero && !ra_neg
    ) else $error("r0 read nonzero");

endmodule

//--- design/instr_fetch.sv
`timescale 1ns/1ns

module instr_fetch
    import cpu_pkg::*;
(
    input  logic               clock,
    input  logic               rst_n,
    input  logic               prog_write,
    input  logic [IMEM_AW-1:0] prog_addr,
    input  logic [XLEN-1:0]    prog_data,
    input  logic [IMEM_AW-1:0] next_pc,
    ctrl_if.fetch              ctl,
    output logic [XLEN-1:0]    ir,
    output logic [IMEM_AW-1:0] pc
);

    logic [XLEN-1:0] prog_mem [IMEM_DEPTH];

    // load port, used while the core sits in t1
    always_ff @(posedge clock)
    begin
        if (prog_write)
            prog_mem[prog_addr] <= prog_data;
    end

    always_ff @(posedge clock)
    begin
        if (ctl.fetch_en)
            ir <= prog_mem[pc];
    end

    // pc points past the current instruction from t2 on
    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            pc <= '0;
        end
        else if (ctl.fetch_en)
        begin
            pc <= pc + 1'b1;
        end
        else if (ctl.phase == t5_write && (ctl.pc_branch || ctl.pc_jump))
        begin
            pc <= next_pc;  // branch target or jump register
        end
    end

    a_prog_write_stopped: assert property (
        @(posedge clock) disable iff (!rst_n)
        prog_write |-> ctl.phase == t1_fetch
    ) else $error("program memory written outside t1");

endmodule

//--- design/mem_if.sv
`timescale 1ns/1ns

interface mem_if
    import cpu_pkg::*;
();
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] rdata;  // latched load data
    logic            read;
    logic            write;

    modport dp (
        output addr, wdata, read, write,
        input  rdata
    );

    modport port (
        input  addr, wdata, read, write,
        output rdata
    );

endinterface

//--- design/mem_port.sv
`timescale 1ns/1ns

module mem_port
    import cpu_pkg::*;
(
    input  logic            clock,
    input  logic            rst_n,
    mem_if.port             mem,
    input  logic [XLEN-1:0] load_data,
    output logic [XLEN-1:0] mem_addr,
    output logic [XLEN-1:0] store_data,
    output logic            store_valid,
    output logic            load_valid
);

    logic [XLEN-1:0] load_q;

    // strobes come only in t4
    assign mem_addr    = mem.addr;
    assign store_data  = mem.wdata;
    assign store_valid = mem.write;
    assign load_valid  = mem.read;

    // external memory answers in the same cycle
    always_ff @(posedge clock)
    begin
        if (mem.read)
            load_q <= load_data;
    end

    assign mem.rdata = load_q;  // valid in t5

    a_strobes_exclusive: assert property (
        @(posedge clock) disable iff (!rst_n)
        !(store_valid && load_valid)
    ) else $error("store and load strobes together");

endmodule

//--- dv/cpu_tb.sv
`timescale 1ns/1ns

module cpu_tb
    import cpu_pkg::*;
();

    logic               clock = 1'b0;
    logic               rst_n;
    logic               run;
    logic               prog_write;
    logic [IMEM_AW-1:0] prog_addr;
    logic [XLEN-1:0]    prog_data;
    logic [XLEN-1:0]    load_data;
    logic [XLEN-1:0]    mem_addr;
    logic [XLEN-1:0]    store_data;
    logic               store_valid;
    logic               load_valid;
    logic               halted;

    logic [XLEN-1:0] prog [IMEM_DEPTH];
    logic [XLEN-1:0] dmem [256];            // external data memory model
    logic [XLEN-1:0] model_regs [NUM_REGS];
    logic [31:0]     lfsr_state = 32'he305;
    int              gen_addr = 0;
    int              prog_len = 0;
    int              exec_count = 0;        // instructions in execution order
    int              cycle = 0;
    int              cycle_limit = 2000;
    int              prev_cycle = 0;
    int              prev_idx = 0;
    bit              have_prev = 1'b0;

    // expected memory accesses, oldest first
    bit              exp_store [$];
    logic [XLEN-1:0] exp_addr [$];
    logic [XLEN-1:0] exp_data [$];
    int              exp_idx [$];
    string           exp_name [$];

    cpu_top u_cpu_top (
        .clock       (clock),
        .rst_n       (rst_n),
        .run         (run),
        .prog_write  (prog_write),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .load_data   (load_data),
        .mem_addr    (mem_addr),
        .store_data  (store_data),
        .store_valid (store_valid),
        .load_valid  (load_valid),
        .halted      (halted)
    );

    always #20 clock = ~clock;

    assign load_data = dmem[mem_addr[7:0]];  // answers in the same cycle

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] sext(input logic [18:0] imm);
        return {{13{imm[18]}}, imm};
    endfunction

    function automatic logic [31:0] enc_r(input opcode_e op, input logic [3:0] ra,
                                          input logic [3:0] rb, input logic [3:0] rc);
        return {op, ra, rb, rc, 15'b0};
    endfunction

    function automatic logic [31:0] enc_i(input opcode_e op, input logic [3:0] ra,
                                          input logic [3:0] rb, input logic [18:0] imm);
        return {op, ra, rb, imm};
    endfunction

    function automatic logic [31:0] alu_rule(input opcode_e op, input logic [31:0] a,
                                             input logic [31:0] b);
        logic [63:0] wide;
        logic [63:0] filled;
        int          n;
        wide   = {a, a};
        filled = {{32{a[31]}}, a};
        n      = int'(b[4:0]);
        case (op)
            op_add, op_addi: return a + b;
            op_sub:          return a - b;
            op_and, op_andi: return a & b;
            op_or, op_ori:   return a | b;
            op_rotr:         return wide[n +: 32];
            op_rotl:         return wide[(32 - n) +: 32];
            op_shr:          return a >> n;
            op_shra:         return filled[n +: 32];
            op_shl:          return a << n;
            op_neg:          return ~a + 32'd1;
            op_not:          return ~a;
            default:         return b;
        endcase
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected == actual)
        else abort_run($sformatf("ERR %s: expected %h, actual %h", name, expected, actual));
    endtask

    task automatic set_reg(input logic [3:0] rd, input logic [31:0] v);
        if (rd != 4'd0)
            model_regs[rd] = v;
    endtask

    task automatic emit(input logic [31:0] word, input bit executed);
        prog[gen_addr] = word;
        gen_addr++;
        if (gen_addr > prog_len)
            prog_len = gen_addr;
        if (executed)
            exec_count++;
    endtask

    task automatic expect_access(input bit is_store, input logic [31:0] addr,
                                 input logic [31:0] data, input string name);
        exp_store.push_back(is_store);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
        exp_idx.push_back(exec_count);  // index of the instruction about to be emitted
        exp_name.push_back(name);
    endtask

    task automatic load_imm(input logic [3:0] rd, input logic [18:0] imm);
        emit(enc_i(op_ldi, rd, 4'd0, imm), 1'b1);
        set_reg(rd, sext(imm));
    endtask

    task automatic store_word(input logic [3:0] src, input logic [18:0] addr,
                              input string name, input bit executed);
        if (executed)
            expect_access(1'b1, sext(addr), model_regs[src], name);
        emit(enc_i(op_st, src, 4'd0, addr), executed);
    endtask

    task automatic load_word(input logic [3:0] rd, input logic [18:0] addr, input string name);
        expect_access(1'b0, sext(addr), '0, name);
        emit(enc_i(op_ld, rd, 4'd0, addr), 1'b1);
        set_reg(rd, dmem[addr[7:0]]);
    endtask

    // result lands in r4 and is stored right after
    task automatic alu_store(input opcode_e op, input logic [3:0] rs1, input logic [3:0] rs2,
                             input bit use_imm, input logic [18:0] imm,
                             input logic [18:0] addr, input string name);
        logic [31:0] b;
        b = use_imm ? sext(imm) : model_regs[rs2];
        emit(use_imm ? enc_i(op, 4'd4, rs1, imm) : enc_r(op, 4'd4, rs1, rs2), 1'b1);
        set_reg(4'd4, alu_rule(op, model_regs[rs1], b));
        store_word(4'd4, addr, name, 1'b1);
    endtask

    // taken branch hops over the marker store
    task automatic branch_skip(input logic [3:0] src, input logic [1:0] cond,
                               input logic [18:0] addr, input string name);
        bit taken;
        case (cond)
            BR_ZERO:    taken = (model_regs[src] == '0);
            BR_NONZERO: taken = (model_regs[src] != '0);
            BR_POS:     taken = !model_regs[src][31];
            default:    taken = model_regs[src][31];
        endcase
        emit({op_br, src, cond, 2'b00, 19'd1}, 1'b1);
        store_word(4'd0, addr, name, !taken);
    endtask

    task automatic build_program();
        logic signed [63:0] product;
        int                 k;
        for (int i = 0; i < 256; i++)
            dmem[i] = 32'(i) * 32'h9e37_79b1 + 32'h0bad_f00d;
        for (int i = 0; i < NUM_REGS; i++)
            model_regs[i] = '0;
        dmem[16] = take_bits(32);
        load_imm(4'd1, 19'(take_bits(19)));
        load_imm(4'd2, 19'(take_bits(19)));
        load_imm(4'd3, 19'(take_bits(5) % 31 + 1));  // shift amount 1 to 31
        alu_store(op_add,  4'd1, 4'd2, 1'b0, '0, 19'h40, "add");
        alu_store(op_sub,  4'd1, 4'd2, 1'b0, '0, 19'h41, "sub");
        alu_store(op_and,  4'd1, 4'd2, 1'b0, '0, 19'h42, "and");
        alu_store(op_or,   4'd1, 4'd2, 1'b0, '0, 19'h43, "or");
        alu_store(op_rotr, 4'd1, 4'd3, 1'b0, '0, 19'h44, "rotr");
        alu_store(op_rotl, 4'd1, 4'd3, 1'b0, '0, 19'h45, "rotl");
        alu_store(op_shr,  4'd1, 4'd3, 1'b0, '0, 19'h46, "shr");
        alu_store(op_shra, 4'd1, 4'd3, 1'b0, '0, 19'h47, "shra");
        alu_store(op_shl,  4'd1, 4'd3, 1'b0, '0, 19'h48, "shl");
        alu_store(op_addi, 4'd1, 4'd0, 1'b1, 19'(take_bits(19)), 19'h49, "addi");
        alu_store(op_andi, 4'd1, 4'd0, 1'b1, 19'(take_bits(19)), 19'h4a, "andi");
        alu_store(op_ori,  4'd1, 4'd0, 1'b1, 19'(take_bits(19)), 19'h4b, "ori");
        alu_store(op_neg,  4'd1, 4'd0, 1'b0, '0, 19'h4c, "neg");
        alu_store(op_not,  4'd1, 4'd0, 1'b0, '0, 19'h4d, "not");
        load_word(4'd5, 19'h10, "ld");
        store_word(4'd5, 19'h50, "ld/st copy", 1'b1);
        emit(enc_r(op_mul, 4'd0, 4'd1, 4'd2), 1'b1);
        product = $signed({{32{model_regs[1][31]}}, model_regs[1]})
                * $signed({{32{model_regs[2][31]}}, model_regs[2]});
        emit(enc_r(op_mfhi, 4'd7, 4'd0, 4'd0), 1'b1);
        set_reg(4'd7, product[63:32]);
        emit(enc_r(op_mflo, 4'd8, 4'd0, 4'd0), 1'b1);
        set_reg(4'd8, product[31:0]);
        store_word(4'd7, 19'h58, "mfhi", 1'b1);
        store_word(4'd8, 19'h59, "mflo", 1'b1);
        load_imm(4'd11, {1'b1, 18'(take_bits(18))});  // always negative
        branch_skip(4'd0,  BR_ZERO,    19'h70, "br zero r0");
        branch_skip(4'd11, BR_ZERO,    19'h71, "br zero r11");
        branch_skip(4'd0,  BR_NONZERO, 19'h72, "br nonzero r0");
        branch_skip(4'd11, BR_NONZERO, 19'h73, "br nonzero r11");
        branch_skip(4'd0,  BR_POS,     19'h74, "br pos r0");
        branch_skip(4'd11, BR_POS,     19'h75, "br pos r11");
        branch_skip(4'd0,  BR_NEG,     19'h76, "br neg r0");
        branch_skip(4'd11, BR_NEG,     19'h77, "br neg r11");
        // subroutine sits past the halt, emitted in execution order
        k = gen_addr;
        load_imm(4'd9, 19'(k + 4));
        emit(enc_i(op_jal, 4'd9, 4'd0, '0), 1'b1);
        set_reg(4'd15, 32'(k + 2));
        gen_addr = k + 4;
        store_word(4'd15, 19'h60, "jal link", 1'b1);
        emit(enc_i(op_jr, 4'd15, 4'd0, '0), 1'b1);
        gen_addr = k + 2;
        store_word(4'd1, 19'h61, "jr return", 1'b1);
        emit(enc_i(op_halt, 4'd0, 4'd0, '0), 1'b1);
    endtask

    always @(posedge clock)
    begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit)
            abort_run("timeout: the core did not halt within the cycle limit");
    end

    always @(posedge clock)
    begin
        if (rst_n && (store_valid || load_valid))
        begin
            assert (exp_addr.size() > 0)
            else abort_run("memory strobe seen when no access was expected");
            check_value({exp_name[0], " kind"}, {31'b0, exp_store[0]}, {31'b0, store_valid});
            check_value({exp_name[0], " addr"}, exp_addr[0], mem_addr);
            if (store_valid)
            begin
                check_value({exp_name[0], " data"}, exp_data[0], store_data);
                dmem[mem_addr[7:0]] = store_data;
            end
            if (have_prev)
                check_value({exp_name[0], " gap"}, 5 * (exp_idx[0] - prev_idx),
                            cycle - prev_cycle);
            prev_idx   = exp_idx[0];
            prev_cycle = cycle;
            have_prev  = 1'b1;
            void'(exp_store.pop_front());
            void'(exp_addr.pop_front());
            void'(exp_data.pop_front());
            void'(exp_idx.pop_front());
            void'(exp_name.pop_front());
        end
    end

    a_store_pulse: assert property (
        @(posedge clock) disable iff (!rst_n) store_valid |=> !store_valid
    ) else abort_run("store_valid held longer than one cycle");

    a_load_pulse: assert property (
        @(posedge clock) disable iff (!rst_n) load_valid |=> !load_valid
    ) else abort_run("load_valid held longer than one cycle");

    a_quiet_in_reset: assert property (
        @(posedge clock) !rst_n |-> !(store_valid || load_valid)
    ) else abort_run("memory strobe during reset");

    a_quiet_after_halt: assert property (
        @(posedge clock) disable iff (!rst_n) halted |-> !(store_valid || load_valid)
    ) else abort_run("memory strobe after halt");

    initial
    begin
        rst_n      = 1'b0;
        run        = 1'b0;
        prog_write = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        build_program();
        cycle_limit = 5 + prog_len + 5 * exec_count + 20 + 60;  // reset, load, run, margin
        repeat (5) @(posedge clock);
        #2;
        rst_n = 1'b1;
        for (int i = 0; i < prog_len; i++)
        begin
            prog_write = 1'b1;
            prog_addr  = IMEM_AW'(i);
            prog_data  = prog[i];
            @(posedge clock);
            #2;
        end
        prog_write = 1'b0;
        run        = 1'b1;
        while (!halted)
            @(posedge clock);
        repeat (20) @(posedge clock);
        if (exp_addr.size() == 0)
        begin
            $display("TEST RESULT: PASS");
            $finish;
        end
        else
        begin
            abort_run($sformatf("%0d expected memory accesses never happened", exp_addr.size()));
        end
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module cpu_tb \
    -Mdir obj_dir -o cpu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/cpu_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
exit 1
